//--- vgaScaler.f
vgaPkg.sv
vgaTiming.sv
scaleAddress.sv
frameBuffer.sv
pixelOut.sv
displayControl.sv
vgaScaler.sv
vgaChecker.sv
tbVgaScaler.sv

//--- runSim.sh
#!/bin/bash
# build and run the vgaScaler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbVgaScaler -f vgaScaler.f -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "\*\*\* FAILED \*\*\*" sim.log &&
{ echo "simulation failed, see sim.log"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

//--- tbVgaScaler.sv
`timescale 1ns/1ns
`default_nettype none

module tbVgaScaler
    import vgaPkg::*;
();

    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;             // 420000
    localparam int VBLANK_AT = V_DISPLAY * H_TOTAL + H_TOTAL;  // one line into vblank
    localparam int LIMIT_CYC = 4 * FRAME_CYC + 20000;

    logic        CLK25 = 1'b0;
    logic        reset;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        hSync;
    logic        vSync;
    logic        blankN;
    logic [7:0]  rgb;

    int          errorCount;
    int          checkCount;
    int          tbCyc = 0;    // edges since reset fell
    int          runCyc = 0;   // edges since time 0
    logic [31:0] seed = 32'd12187;

    always #2 CLK25 = ~CLK25;   // 4 ns period

    vgaScaler u_vgaScaler (
        .CLK25(CLK25), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .hSync(hSync), .vSync(vSync), .blankN(blankN), .rgb(rgb)
    );

    vgaChecker u_checker (
        .CLK25(CLK25), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .hSync(hSync), .vSync(vSync), .blankN(blankN), .rgb(rgb),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    // ==============================
    // cycle counters and timeout
    // ==============================
    always @(posedge CLK25) begin
        runCyc <= runCyc + 1;
        if (reset)
            tbCyc <= 0;
        else
            tbCyc <= tbCyc + 1;
        if (runCyc == LIMIT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
            endRun(1'b1);
        end
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'b0, seed[30:15]};                 // upper bits spread better
    endfunction

    task automatic endRun(input bit timedOut);
        int total;
        total = errorCount + (timedOut ? 1 : 0);
        $display("run end: %0d checks, %0d errors", checkCount, total);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    task automatic nextCycle();
        @(posedge CLK25);
        #1;                                          // drive just after the edge
    endtask

    task automatic waitUntil(input int target);
        while (tbCyc < target)
            nextCycle();
    endtask

    // hold both valids until the ready pulse, then stall bready 0 to 3 cycles
    task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data);
        int stall;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge CLK25); while (!awready);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        stall = int'(lcgNext() % 4);
        repeat (stall) nextCycle();
        bready = 1'b1;
        do @(posedge CLK25); while (!bvalid);
        #1;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [4:0] addr);
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge CLK25); while (!arready);
        #1;
        arvalid = 1'b0;
        stall = int'(lcgNext() % 4);
        repeat (stall) nextCycle();
        rready = 1'b1;
        do @(posedge CLK25); while (!rvalid);
        #1;
        rready = 1'b0;
    endtask

    task automatic pixelBurst(input int count);
        for (int i = 0; i < count; i++)
            axiWrite(REG_PIXDATA, {24'b0, 8'(lcgNext())});
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hF;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (16) @(posedge CLK25);
        #1 reset = 1'b0;

        // frame 0 vblank sets the background only
        waitUntil(VBLANK_AT);
        axiWrite(REG_CTRL, 32'd0);
        axiWrite(REG_BGCOLOR, {24'b0, 8'(lcgNext())});

        // frame 1 vblank loads pixels and one burst wraps past the last word
        waitUntil(FRAME_CYC + VBLANK_AT);
        for (int b = 0; b < 3; b++) begin
            axiWrite(REG_PIXADDR, lcgNext() % 32'(FB_DEPTH));
            pixelBurst(8 + int'(lcgNext() % 32));
        end
        axiWrite(REG_PIXADDR, 32'(FB_DEPTH - 6));
        pixelBurst(14);
        axiRead(REG_PIXADDR);                        // wrapped to 8
        axiWrite(REG_CTRL, 32'd1);

        // frame 2 vblank checks error responses and register readback
        waitUntil(2 * FRAME_CYC + VBLANK_AT);
        axiWrite(REG_STATUS, 32'd5);
        axiWrite(5'h14, 32'd1);
        axiWrite(5'h1C, 32'd1);
        axiRead(REG_PIXDATA);
        axiRead(5'h18);
        axiRead(REG_CTRL);
        axiRead(REG_BGCOLOR);
        axiRead(REG_PIXADDR);
        axiRead(REG_STATUS);

        // counter reads 3 early in frame 3
        waitUntil(3 * FRAME_CYC + 2000);
        axiRead(REG_STATUS);
        waitUntil(3 * FRAME_CYC + 4000);
        endRun(1'b0);
    end

endmodule

`default_nettype wire

//--- vgaChecker.sv
`timescale 1ns/1ns
`default_nettype none

module vgaChecker
    import vgaPkg::*;
(
    input  wire logic        CLK25,
    input  wire logic        reset,
    input  wire logic [4:0]  awaddr,
    input  wire logic        awvalid,
    input  wire logic        awready,
    input  wire logic [31:0] wdata,
    input  wire logic        wvalid,
    input  wire logic        wready,
    input  wire logic [1:0]  bresp,
    input  wire logic        bvalid,
    input  wire logic        bready,
    input  wire logic [4:0]  araddr,
    input  wire logic        arvalid,
    input  wire logic        arready,
    input  wire logic [31:0] rdata,
    input  wire logic [1:0]  rresp,
    input  wire logic        rvalid,
    input  wire logic        rready,
    input  wire logic        hSync,
    input  wire logic        vSync,
    input  wire logic        blankN,
    input  wire logic [7:0]  rgb,
    output int               errorCount,
    output int               checkCount
);

    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;

    // register and memory model
    logic        enModel;
    logic [7:0]  bgModel;
    int          pixAddrModel;
    logic        enD1;          // model one edge back as pixelOut samples it
    logic [7:0]  bgD1;
    logic [7:0]  fbModel [0:FB_DEPTH-1];
    bit          written [0:FB_DEPTH-1];   // only loaded pixels are compared
    int          cyc;
    logic [1:0]  expB;
    logic [31:0] expRdata;
    logic [1:0]  expR;
    bit          wAccD;
    bit          rAccD;

    initial begin
        errorCount = 0;
        checkCount = 0;
        for (int i = 0; i < FB_DEPTH; i++)
            written[i] = 1'b0;
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic failNote(input string what);
        errorCount++;
        $display("error at %0t: %s", $time, what);
    endtask

    // ==============================
    // video model at position cyc-3
    // ==============================
    task automatic checkVideo();
        int   p;
        int   h;
        int   v;
        int   a;
        logic eH;
        logic eV;
        logic eB;
        if (cyc < 3) begin
            eH = 1'b1;                                 // pipeline still in reset
            eV = 1'b1;
            eB = 1'b0;
        end else begin
            p  = (cyc - 3) % FRAME_CYC;
            h  = p % H_TOTAL;
            v  = p / H_TOTAL;
            eH = !(h >= H_DISPLAY + H_FRONT && h < H_DISPLAY + H_FRONT + H_SYNC);
            eV = !(v >= V_DISPLAY + V_FRONT && v < V_DISPLAY + V_FRONT + V_SYNC);
            eB = (h < H_DISPLAY) && (v < V_DISPLAY);
        end
        checkVal("hSync", 32'(hSync), 32'(eH));
        checkVal("vSync", 32'(vSync), 32'(eV));
        checkVal("blankN", 32'(blankN), 32'(eB));
        if (!eB) begin
            checkVal("rgb", 32'(rgb), 32'd0);          // black in blanking
        end else if (!enD1) begin
            checkVal("rgb", 32'(rgb), 32'(bgD1));
        end else begin
            a = (v / 2) * SRC_WIDTH + h / 2;
            if (written[a])
                checkVal("rgb", 32'(rgb), 32'(fbModel[a]));
        end
    endtask

    // ==============================
    // per-edge watch on pre-edge values
    // ==============================
    always @(posedge CLK25) begin
        if (reset) begin
            cyc = 0;
            enModel = 1'b0;
            bgModel = 8'd0;
            pixAddrModel = 0;
            enD1 = 1'b0;
            bgD1 = 8'd0;
            wAccD = 1'b0;
            rAccD = 1'b0;
        end else begin
            checkVideo();
            enD1 = enModel;
            bgD1 = bgModel;
            if (wAccD && !bvalid)
                failNote("bvalid did not rise one cycle after the write was accepted");
            if (rAccD && !rvalid)
                failNote("rvalid did not rise one cycle after the read was accepted");
            wAccD = 1'b0;
            rAccD = 1'b0;

            if (bvalid && bready)
                checkVal("bresp", 32'(bresp), 32'(expB));
            if (rvalid && rready) begin
                checkVal("rresp", 32'(rresp), 32'(expR));
                checkVal("rdata", rdata, expRdata);
            end

            if (awready !== wready)
                failNote("awready and wready did not pulse together");
            if (awready && bvalid)
                failNote("awready rose while a write response was still held");
            if (arready && rvalid)
                failNote("arready rose while a read response was still held");
            if (awvalid && awready && wvalid && wready) begin
                wAccD = 1'b1;
                expB  = RESP_OKAY;
                case (awaddr)
                    REG_CTRL:    enModel = wdata[0];
                    REG_BGCOLOR: bgModel = wdata[7:0];
                    REG_PIXADDR: pixAddrModel = int'(wdata[16:0]);
                    REG_PIXDATA: begin
                        fbModel[pixAddrModel] = wdata[7:0];
                        written[pixAddrModel] = 1'b1;
                        pixAddrModel = (pixAddrModel + 1) % FB_DEPTH;   // wraps to 0
                    end
                    default:     expB = RESP_SLVERR;
                endcase
            end

            if (arvalid && arready) begin
                rAccD = 1'b1;
                expR  = RESP_OKAY;
                case (araddr)
                    REG_CTRL:    expRdata = {31'b0, enModel};
                    REG_BGCOLOR: expRdata = {24'b0, bgModel};
                    REG_PIXADDR: expRdata = 32'(pixAddrModel);
                    // counter captured before this edge skips the first frameStart
                    REG_STATUS:  expRdata = (cyc == 0) ? 32'd0 : 32'((cyc - 1) / FRAME_CYC);
                    default: begin
                        expRdata = 32'd0;
                        expR     = RESP_SLVERR;
                    end
                endcase
            end
            cyc = cyc + 1;
        end
    end

endmodule

`default_nettype wire

//--- vgaScaler.sv
`timescale 1ns/1ns
`default_nettype none

module vgaScaler
    import vgaPkg::*;
(
    input  wire logic                   CLK25,
    input  wire logic                   reset,
    // AXI4-Lite slave
    input  wire logic [AXI_ADDR_W-1:0]  awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire logic [AXI_DATA_W-1:0]  wdata,
    input  wire logic [3:0]             wstrb,
    input  wire logic                   wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    input  wire logic [AXI_ADDR_W-1:0]  araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output logic [AXI_DATA_W-1:0]       rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire logic                   rready,
    // VGA
    output logic                        hSync,
    output logic                        vSync,
    output logic                        blankN,
    output logic [PIX_W-1:0]            rgb
);

    logic [9:0]           hCount;
    logic [9:0]           vCount;
    logic                 hSyncEarly;
    logic                 vSyncEarly;
    logic                 activeEarly;
    logic                 frameStart;
    logic [FB_ADDR_W-1:0] fbRdAddr;
    logic [PIX_W-1:0]     fbRdData;
    logic                 fbWrEn;
    logic [FB_ADDR_W-1:0] fbWrAddr;
    logic [PIX_W-1:0]     fbWrData;
    logic                 enable;
    logic [PIX_W-1:0]     bgColor;

    // ==============================
    // host side
    // ==============================
    displayControl u_displayControl (
        .CLK25(CLK25), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .frameStart(frameStart),
        .enable(enable), .bgColor(bgColor),
        .fbWrEn(fbWrEn), .fbWrAddr(fbWrAddr), .fbWrData(fbWrData)
    );

    // ==============================
    // video pipeline, 3 stages
    // ==============================
    vgaTiming u_vgaTiming (
        .CLK25(CLK25), .reset(reset),
        .hCount(hCount), .vCount(vCount),
        .hSyncEarly(hSyncEarly), .vSyncEarly(vSyncEarly),
        .activeEarly(activeEarly), .frameStart(frameStart)
    );

    scaleAddress u_scaleAddress (            // stage 1
        .CLK25(CLK25), .reset(reset),
        .hCount(hCount), .vCount(vCount),
        .fbRdAddr(fbRdAddr)
    );

    frameBuffer u_frameBuffer (              // stage 2
        .CLK25(CLK25),
        .fbWrEn(fbWrEn), .fbWrAddr(fbWrAddr), .fbWrData(fbWrData),
        .fbRdAddr(fbRdAddr), .fbRdData(fbRdData)
    );

    pixelOut u_pixelOut (                    // stage 3
        .CLK25(CLK25), .reset(reset),
        .hSyncEarly(hSyncEarly), .vSyncEarly(vSyncEarly),
        .activeEarly(activeEarly), .fbRdData(fbRdData),
        .enable(enable), .bgColor(bgColor),
        .hSync(hSync), .vSync(vSync), .blankN(blankN), .rgb(rgb)
    );

endmodule

`default_nettype wire

//--- displayControl.sv
`timescale 1ns/1ns
`default_nettype none

module displayControl
    import vgaPkg::*;
(
    input  wire logic                   CLK25,
    input  wire logic                   reset,
    // write address / data / response
    input  wire logic [AXI_ADDR_W-1:0]  awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire logic [AXI_DATA_W-1:0]  wdata,
    input  wire logic [3:0]             wstrb,    // full-word writes only
    input  wire logic                   wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    // read address / data
    input  wire logic [AXI_ADDR_W-1:0]  araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output logic [AXI_DATA_W-1:0]       rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire logic                   rready,
    // video side
    input  wire logic                   frameStart,
    output logic                        enable,
    output logic [PIX_W-1:0]            bgColor,
    output logic                        fbWrEn,
    output logic [FB_ADDR_W-1:0]        fbWrAddr,
    output logic [PIX_W-1:0]            fbWrData
);

    writeState_e          wState;
    readState_e           rState;
    axiResp_e             bRespQ;
    axiResp_e             rRespQ;
    logic [FB_ADDR_W-1:0] pixAddr;
    logic [15:0]          frameCount;
    logic                 firstSeen;   // first frameStart is not counted
    logic                 wrAccept;
    logic                 rdAccept;

    assign wrAccept = awready && awvalid;  // wready/wvalid rise alongside
    assign rdAccept = arready && arvalid;

    assign bvalid = (wState == W_RESP);
    assign rvalid = (rState == R_DATA);
    assign bresp  = bRespQ;
    assign rresp  = rRespQ;

    // ==============================
    // write channel + registers
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            wState   <= W_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bRespQ   <= RESP_OKAY;
            enable   <= 1'b0;
            bgColor  <= '0;
            pixAddr  <= '0;
            fbWrEn   <= 1'b0;
            fbWrAddr <= '0;
            fbWrData <= '0;
        end else begin
            fbWrEn <= 1'b0;                               // single-cycle command
            if (fbWrEn) begin                             // advance after the store
                if (fbWrAddr == FB_ADDR_W'(FB_DEPTH - 1))
                    pixAddr <= '0;
                else
                    pixAddr <= fbWrAddr + FB_ADDR_W'(1);
            end
            case (wState)
                W_IDLE: begin
                    if (wrAccept) begin
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        wState  <= W_RESP;
                        bRespQ  <= RESP_OKAY;
                        case (awaddr)
                            REG_CTRL:    enable  <= wdata[0];
                            REG_BGCOLOR: bgColor <= wdata[PIX_W-1:0];
                            REG_PIXADDR: pixAddr <= wdata[FB_ADDR_W-1:0];
                            REG_PIXDATA: begin
                                fbWrEn   <= 1'b1;
                                fbWrAddr <= pixAddr;
                                fbWrData <= wdata[PIX_W-1:0];
                            end
                            default:     bRespQ  <= RESP_SLVERR;  // status or unmapped
                        endcase
                    end else begin
                        // pulse ready once when both channels are present
                        awready <= awvalid && wvalid && !awready;
                        wready  <= awvalid && wvalid && !awready;
                    end
                end
                W_RESP: begin
                    if (bready)
                        wState <= W_IDLE;                 // hold until host takes it
                end
                default: wState <= W_IDLE;
            endcase
        end
    end

    // ==============================
    // read channel
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            rState  <= R_IDLE;
            arready <= 1'b0;
            rdata   <= '0;
            rRespQ  <= RESP_OKAY;
        end else begin
            case (rState)
                R_IDLE: begin
                    if (rdAccept) begin
                        arready <= 1'b0;
                        rState  <= R_DATA;
                        rRespQ  <= RESP_OKAY;
                        case (araddr)
                            REG_CTRL:    rdata <= {31'b0, enable};
                            REG_BGCOLOR: rdata <= {24'b0, bgColor};
                            REG_PIXADDR: rdata <= {15'b0, pixAddr};
                            REG_STATUS:  rdata <= {16'b0, frameCount};
                            default: begin                // pixdata or unmapped
                                rdata  <= '0;
                                rRespQ <= RESP_SLVERR;
                            end
                        endcase
                    end else begin
                        arready <= arvalid && !arready;
                    end
                end
                R_DATA: begin
                    if (rready)
                        rState <= R_IDLE;
                end
                default: rState <= R_IDLE;
            endcase
        end
    end

    // frame counter skips the pulse at cycle 0
    always_ff @(posedge CLK25) begin
        if (reset) begin
            frameCount <= '0;
            firstSeen  <= 1'b0;
        end else if (frameStart) begin
            firstSeen <= 1'b1;
            if (firstSeen)
                frameCount <= frameCount + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- pixelOut.sv
`timescale 1ns/1ns
`default_nettype none

module pixelOut
    import vgaPkg::*;
(
    input  wire logic              CLK25,
    input  wire logic              reset,
    input  wire logic              hSyncEarly,
    input  wire logic              vSyncEarly,
    input  wire logic              activeEarly,
    input  wire logic [PIX_W-1:0]  fbRdData,
    input  wire logic              enable,      // show frame buffer
    input  wire logic [PIX_W-1:0]  bgColor,     // shown while disabled
    output logic                   hSync,
    output logic                   vSync,
    output logic                   blankN,
    output logic [PIX_W-1:0]       rgb
);

    logic hSyncDly;
    logic vSyncDly;
    logic activeDly;

    // ==============================
    // match memory read latency
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            hSyncDly  <= 1'b1;
            vSyncDly  <= 1'b1;
            activeDly <= 1'b0;
        end else begin
            hSyncDly  <= hSyncEarly;
            vSyncDly  <= vSyncEarly;
            activeDly <= activeEarly;              // now lines up with fbRdData
        end
    end

    // ==============================
    // output register
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            hSync  <= 1'b1;
            vSync  <= 1'b1;
            blankN <= 1'b0;
            rgb    <= '0;
        end else begin
            hSync  <= hSyncDly;
            vSync  <= vSyncDly;
            blankN <= activeDly;
            if (!activeDly)
                rgb <= '0;                         // black in blanking
            else if (enable)
                rgb <= fbRdData;
            else
                rgb <= bgColor;
        end
    end

endmodule

`default_nettype wire

//--- frameBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module frameBuffer
    import vgaPkg::*;
(
    input  wire logic                  CLK25,
    input  wire logic                  fbWrEn,
    input  wire logic [FB_ADDR_W-1:0]  fbWrAddr,
    input  wire logic [PIX_W-1:0]      fbWrData,
    input  wire logic [FB_ADDR_W-1:0]  fbRdAddr,
    output logic [PIX_W-1:0]           fbRdData    // one cycle after fbRdAddr
);

    // ==============================
    // 320x240 pixel store
    // ==============================
    logic [PIX_W-1:0] mem [0:FB_DEPTH-1];

    // write port, host side
    always_ff @(posedge CLK25) begin
        if (fbWrEn)
            mem[fbWrAddr] <= fbWrData;
    end

    // read port, video side
    // same-address collision returns old contents
    always_ff @(posedge CLK25) begin
        fbRdData <= mem[fbRdAddr];
    end

endmodule

`default_nettype wire

//--- scaleAddress.sv
`timescale 1ns/1ns
`default_nettype none

module scaleAddress
    import vgaPkg::*;
(
    input  wire logic                 CLK25,
    input  wire logic                 reset,
    input  wire logic [9:0]           hCount,
    input  wire logic [9:0]           vCount,
    output logic [FB_ADDR_W-1:0]      fbRdAddr   // valid one cycle after counters
);

    logic [8:0]           srcCol;     // 0..319
    logic [8:0]           srcRow;     // 0..239
    logic [FB_ADDR_W-1:0] lineBase;
    logic [FB_ADDR_W-1:0] addrNext;
    logic                 inDisplay;

    // nearest neighbour, each source pixel repeats 2x2
    assign srcCol = hCount[9:1];
    assign srcRow = vCount[9:1];

    // row * 320 = row * 256 + row * 64
    assign lineBase = {srcRow, 8'b0} + {2'b0, srcRow, 6'b0};
    assign addrNext = lineBase + {8'b0, srcCol};

    assign inDisplay = (hCount < 10'(H_DISPLAY)) && (vCount < 10'(V_DISPLAY));

    always_ff @(posedge CLK25) begin
        if (reset)
            fbRdAddr <= '0;
        else if (inDisplay)
            fbRdAddr <= addrNext;
        else
            fbRdAddr <= '0;                    // park at 0 during blanking
    end

endmodule

`default_nettype wire

//--- vgaTiming.sv
`timescale 1ns/1ns
`default_nettype none

module vgaTiming
    import vgaPkg::*;
(
    input  wire logic       CLK25,
    input  wire logic       reset,
    output logic [9:0]      hCount,       // 0..799
    output logic [9:0]      vCount,       // 0..524
    output logic            hSyncEarly,   // active low, one cycle behind counters
    output logic            vSyncEarly,
    output logic            activeEarly,
    output logic            frameStart    // high while both counters sit at 0
);

    logic hLast;
    logic vLast;
    logic hInSync;
    logic vInSync;
    logic inDisplay;

    assign hLast = (hCount == 10'(H_TOTAL - 1));
    assign vLast = (vCount == 10'(V_TOTAL - 1));

    // ==============================
    // raster counters
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            hCount <= 10'd0;
            vCount <= 10'd0;
        end else if (hLast) begin
            hCount <= 10'd0;                  // end of line
            if (vLast)
                vCount <= 10'd0;              // end of frame
            else
                vCount <= vCount + 10'd1;
        end else begin
            hCount <= hCount + 10'd1;
        end
    end

    // sync windows sit after the front porch
    assign hInSync = (hCount >= 10'(H_DISPLAY + H_FRONT)) &&
                     (hCount <  10'(H_DISPLAY + H_FRONT + H_SYNC));
    assign vInSync = (vCount >= 10'(V_DISPLAY + V_FRONT)) &&
                     (vCount <  10'(V_DISPLAY + V_FRONT + V_SYNC));
    assign inDisplay = (hCount < 10'(H_DISPLAY)) && (vCount < 10'(V_DISPLAY));

    // ==============================
    // registered sync / active
    // ==============================
    always_ff @(posedge CLK25) begin
        if (reset) begin
            hSyncEarly  <= 1'b1;              // idle high
            vSyncEarly  <= 1'b1;
            activeEarly <= 1'b0;
        end else begin
            hSyncEarly  <= ~hInSync;
            vSyncEarly  <= ~vInSync;
            activeEarly <= inDisplay;
        end
    end

    // counters at origin -> start of a new frame
    assign frameStart = (hCount == 10'd0) && (vCount == 10'd0);

endmodule

`default_nettype wire

//--- vgaPkg.sv
`default_nettype none

package vgaPkg;

    // ==============================
    // 640x480 @ 60 Hz raster timing
    // ==============================
    localparam int H_DISPLAY = 640;   // visible pixels per line
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_DISPLAY = 480;   // visible lines per frame
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;  // 525

    // ==============================
    // source frame buffer
    // ==============================
    localparam int SRC_WIDTH  = 320;
    localparam int SRC_HEIGHT = 240;
    localparam int FB_DEPTH   = SRC_WIDTH * SRC_HEIGHT;  // 76800 words
    localparam int FB_ADDR_W  = 17;
    localparam int PIX_W      = 8;                       // rgb332

    // ==============================
    // AXI4-Lite register map
    // ==============================
    localparam int AXI_ADDR_W = 5;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 5'h00;  // bit 0 enable
    localparam logic [AXI_ADDR_W-1:0] REG_BGCOLOR = 5'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_PIXADDR = 5'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_PIXDATA = 5'h0C;  // write only
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS  = 5'h10;  // read only, frame count

    typedef enum logic {W_IDLE, W_RESP} writeState_e;
    typedef enum logic {R_IDLE, R_DATA} readState_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiResp_e;

endpackage

`default_nettype wire
